/* source/agc_pkg.sv */
// Address, word and bank types plus the fixed memory-map constants of the translator
package agc_pkg;

  // Machine data word, as written to the bank registers
  typedef logic [14:0] word_t;

  // Software address as the program sees it
  typedef logic [11:0] soft_addr_t;

  // Physical fixed-memory (ROM) address
  typedef logic [13:0] rom_addr_t;

  // Physical erasable-memory (RAM) address
  typedef logic [10:0] ram_addr_t;

  // One bank field, EB or FB
  typedef logic [2:0] bank_t;

  // Bank register write select
  typedef logic [1:0] bank_sel_t;

  // Select codes; code 3 is unused and writes nothing
  localparam bank_sel_t BANK_SEL_EB = 2'd0;
  localparam bank_sel_t BANK_SEL_FB = 2'd1;
  localparam bank_sel_t BANK_SEL_BB = 2'd2;

  // Software addresses at or above this are ROM
  localparam soft_addr_t ROM_REGION_BASE = 12'o2000;

  // Start of fixed-fixed ROM in software space
  localparam soft_addr_t FIXED_ROM_BASE = 12'o4000;

  // Start of banked erasable memory in software space
  localparam soft_addr_t BANKED_RAM_BASE = 12'o1400;

  // Size of one switched ROM bank
  localparam rom_addr_t ROM_BANK_SIZE = 14'o2000;

  // Size of one switched RAM bank
  localparam ram_addr_t RAM_BANK_SIZE = 11'o0400;

  // RAM offset when the top EB bit is set
  localparam ram_addr_t RAM_HIGH_OFFSET = 11'o2000;

  // Bank field positions inside a data word
  localparam int EB_LSB = 9;
  localparam int FB_LSB = 12;

endpackage

/* source/bank_map_if.sv */
// Interface between bank registers, the two address maps and the access stage
interface bank_map_if
  import agc_pkg::*;
();

  // Software address from the request port
  soft_addr_t soft_addr;

  // Current bank bits
  bank_t eb;
  bank_t fb;

  // Translated addresses, both computed every cycle
  rom_addr_t rom_addr;
  ram_addr_t ram_addr;

  // Bank register side
  modport bank_side (output eb, fb);

  // ROM map only needs FB
  modport rom_side (input soft_addr, fb, output rom_addr);

  // RAM map only needs EB
  modport ram_side (input soft_addr, eb, output ram_addr);

  // Region select and response stage
  modport access_side (input soft_addr, rom_addr, ram_addr);

endinterface

/* source/bank_regs.sv */
// EB and FB bank registers with their write port
module bank_regs
  import agc_pkg::*;
(
  input  logic        clk,
  input  logic        rst_l,
  input  logic        bank_wr_en,
  input  bank_sel_t   bank_wr_sel,
  input  word_t       bank_wr_data,
  bank_map_if.bank_side map
);

  // Held bank fields
  bank_t eb;
  bank_t fb;

  // Bank fields as they sit in the data word
  bank_t wr_eb;
  bank_t wr_fb;

  assign wr_eb = bank_wr_data[EB_LSB +: $bits(bank_t)];
  assign wr_fb = bank_wr_data[FB_LSB +: $bits(bank_t)];

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      eb <= '0;
      fb <= '0;
    end else if (bank_wr_en) begin
      case (bank_wr_sel)
        BANK_SEL_EB: begin
          eb <= wr_eb;
        end
        BANK_SEL_FB: begin
          fb <= wr_fb;
        end
        // Both banks from one word
        BANK_SEL_BB: begin
          eb <= wr_eb;
          fb <= wr_fb;
        end
        default: begin
          // Unused code, both banks hold
          eb <= eb;
          fb <= fb;
        end
      endcase
    end
  end

  // Registered values go straight to both maps
  assign map.eb = eb;
  assign map.fb = fb;

endmodule

/* source/rom_bank_map.sv */
// Fixed-fixed and banked translation from software address to ROM address
module rom_bank_map
  import agc_pkg::*;
(
  bank_map_if.rom_side map
);

  // Address lies in fixed-fixed ROM
  logic      in_fixed;

  // Offset of the selected switched bank
  rom_addr_t bank_offset;

  // Candidate addresses for each region
  rom_addr_t fixed_addr;
  rom_addr_t banked_addr;

  assign in_fixed = (map.soft_addr >= FIXED_ROM_BASE);

  // Fixed-fixed maps to the bottom of physical ROM
  assign fixed_addr = rom_addr_t'(map.soft_addr - FIXED_ROM_BASE);

  // Lookup table on FB, constant products only
  always_comb begin
    case (map.fb)
      3'd0:    bank_offset = '0;
      3'd1:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 1);
      3'd2:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 2);
      3'd3:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 3);
      3'd4:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 4);
      3'd5:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 5);
      3'd6:    bank_offset = rom_addr_t'(ROM_BANK_SIZE * 6);
      default: bank_offset = rom_addr_t'(ROM_BANK_SIZE * 7);
    endcase
  end

  // Switched banks sit one bank above the fixed-fixed area
  assign banked_addr = rom_addr_t'(map.soft_addr) + ROM_BANK_SIZE + bank_offset;

  // Only meaningful when the access stage picks ROM
  assign map.rom_addr = in_fixed ? fixed_addr : banked_addr;

endmodule

/* source/ram_bank_map.sv */
// Unswitched and banked translation from software address to RAM address
module ram_bank_map
  import agc_pkg::*;
(
  bank_map_if.ram_side map
);

  // Address lies in unswitched erasable memory
  logic      in_fixed;

  // Offset from the low EB bits
  ram_addr_t low_offset;

  // Offset after the high-bank override
  ram_addr_t bank_offset;

  // Low address bits shared by both regions
  ram_addr_t base_addr;

  assign in_fixed  = (map.soft_addr < BANKED_RAM_BASE);
  assign base_addr = map.soft_addr[$bits(ram_addr_t)-1:0];

  // Four small banks from EB bits 1..0
  always_comb begin
    case (map.eb[1:0])
      2'd0:    low_offset = '0;
      2'd1:    low_offset = ram_addr_t'(RAM_BANK_SIZE * 1);
      2'd2:    low_offset = ram_addr_t'(RAM_BANK_SIZE * 2);
      default: low_offset = ram_addr_t'(RAM_BANK_SIZE * 3);
    endcase
  end

  // Top EB bit forces the high offset, low bits ignored then
  assign bank_offset = map.eb[2] ? RAM_HIGH_OFFSET : low_offset;

  // Unswitched region passes straight through
  assign map.ram_addr = in_fixed ? base_addr : ram_addr_t'(base_addr + bank_offset);

endmodule

/* source/access_stage.sv */
// Region select, ROM write protection and the registered valid/ready response stage
module access_stage
  import agc_pkg::*;
(
  input  logic      clk,
  input  logic      rst_l,
  input  logic      req_valid,
  input  logic      req_write,
  input  logic      rsp_ready,
  output logic      req_ready,
  bank_map_if.access_side map,
  output logic      rsp_valid,
  output logic      rsp_is_rom,
  output logic      rsp_write,
  output rom_addr_t rsp_rom_addr,
  output ram_addr_t rsp_ram_addr
);

  // Region of the current request
  logic      is_rom;

  // Translated address of the other region is zeroed
  rom_addr_t sel_rom_addr;
  ram_addr_t sel_ram_addr;

  // Write flag after protection
  logic      write_ok;

  // Request handshake
  logic      req_fire;

  assign is_rom       = (map.soft_addr >= ROM_REGION_BASE);
  assign sel_rom_addr = is_rom ? map.rom_addr : '0;
  assign sel_ram_addr = is_rom ? '0 : map.ram_addr;

  // ROM is read-only
  assign write_ok = req_write & ~is_rom;

  // Slot is free, or it drains this cycle
  assign req_ready = ~rsp_valid | rsp_ready;
  assign req_fire  = req_valid & req_ready;

  // Valid bit follows the slot state
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      rsp_valid <= 1'b0;
    end else if (req_ready) begin
      rsp_valid <= req_valid;
    end
  end

  // Response flags
  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      rsp_is_rom <= 1'b0;
      rsp_write  <= 1'b0;
    end else if (req_fire) begin
      rsp_is_rom <= is_rom;
      rsp_write  <= write_ok;
    end
  end

  // Addresses load only on a handshake, held while stalled
  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_rom_addr <= sel_rom_addr;
      rsp_ram_addr <= sel_ram_addr;
    end
  end

endmodule

/* source/agc_addr_xlate.sv */
// Top level of the bank-switched address translator
module agc_addr_xlate
  import agc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,

  // Bank register write port, always accepted
  input  logic       bank_wr_en,
  input  bank_sel_t  bank_wr_sel,
  input  word_t      bank_wr_data,

  // Request
  input  logic       req_valid,
  output logic       req_ready,
  input  soft_addr_t req_addr,
  input  logic       req_write,

  // Response
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output logic       rsp_is_rom,
  output rom_addr_t  rsp_rom_addr,
  output ram_addr_t  rsp_ram_addr,
  output logic       rsp_write
);

  bank_map_if map_if ();

  // Request address feeds both maps
  assign map_if.soft_addr = req_addr;

  bank_regs i_bank_regs (
    .clk          (clk),
    .rst_l        (rst_l),
    .bank_wr_en   (bank_wr_en),
    .bank_wr_sel  (bank_wr_sel),
    .bank_wr_data (bank_wr_data),
    .map          (map_if.bank_side)
  );

  // Both translations run side by side
  rom_bank_map i_rom_bank_map (
    .map (map_if.rom_side)
  );

  ram_bank_map i_ram_bank_map (
    .map (map_if.ram_side)
  );

  access_stage i_access_stage (
    .clk          (clk),
    .rst_l        (rst_l),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .rsp_ready    (rsp_ready),
    .req_ready    (req_ready),
    .map          (map_if.access_side),
    .rsp_valid    (rsp_valid),
    .rsp_is_rom   (rsp_is_rom),
    .rsp_write    (rsp_write),
    .rsp_rom_addr (rsp_rom_addr),
    .rsp_ram_addr (rsp_ram_addr)
  );

endmodule

/* bench/agc_addr_xlate_checker.sv */
// Handshake and response consistency assertions, bound into the translator top level
module agc_addr_xlate_checker
  import agc_pkg::*;
(
  input logic      clk,
  input logic      rst_l,
  input logic      rsp_valid,
  input logic      rsp_ready,
  input logic      rsp_is_rom,
  input rom_addr_t rsp_rom_addr,
  input ram_addr_t rsp_ram_addr,
  input logic      rsp_write
);

  // Slot empty right after reset release
  assert property (@(posedge clk) $rose(rst_l) |-> !rsp_valid)
    else $error("rsp_valid high in the cycle after reset");

  // Stalled response holds every field
  assert property (@(posedge clk) disable iff (!rst_l)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_is_rom) && $stable(rsp_write)
      && $stable(rsp_rom_addr) && $stable(rsp_ram_addr)))
    else $error("Response changed while stalled");

  // ROM is never written
  assert property (@(posedge clk) disable iff (!rst_l)
    (rsp_valid && rsp_write) |-> !rsp_is_rom)
    else $error("Write response on a ROM access");

  // RAM address zeroed on ROM accesses
  assert property (@(posedge clk) disable iff (!rst_l)
    (rsp_valid && rsp_is_rom) |-> (rsp_ram_addr == '0))
    else $error("Nonzero RAM address on a ROM access");

endmodule

bind agc_addr_xlate agc_addr_xlate_checker i_agc_addr_xlate_checker (
  .clk          (clk),
  .rst_l        (rst_l),
  .rsp_valid    (rsp_valid),
  .rsp_ready    (rsp_ready),
  .rsp_is_rom   (rsp_is_rom),
  .rsp_rom_addr (rsp_rom_addr),
  .rsp_ram_addr (rsp_ram_addr),
  .rsp_write    (rsp_write)
);

/* bench/agc_addr_xlate_tb.sv */
// Testbench for the address translator, driven and checked from the tests file
module agc_addr_xlate_tb
  import agc_pkg::*;
();

  // Longest tests file accepted
  localparam int MAX_LINES = 64;

  logic       clk = 1'b0;
  logic       rst_l;
  logic       bank_wr_en;
  bank_sel_t  bank_wr_sel;
  word_t      bank_wr_data;
  logic       req_valid;
  logic       req_ready;
  soft_addr_t req_addr;
  logic       req_write;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       rsp_is_rom;
  rom_addr_t  rsp_rom_addr;
  ram_addr_t  rsp_ram_addr;
  logic       rsp_write;

  // Test lines with the kind in the top nibble
  // A zero kind ends the list
  logic [75:0] tests [0:MAX_LINES-1];
  int          num_lines;
  int          timeout_limit;
  int          cycle_count;

  // Expected responses in request order
  int          exp_line_q[$];
  soft_addr_t  exp_addr_q[$];
  logic        exp_is_rom_q[$];
  rom_addr_t   exp_rom_q[$];
  ram_addr_t   exp_ram_q[$];
  logic        exp_write_q[$];

  // Driver side counts
  int          req_count;
  int          write_count;
  int          drive_errors;

  // Monitor side counts
  int          rsp_count;
  int          pass_count;
  int          fail_count;
  int          monitor_errors;

  integer      seed = 32'hb841;
  logic [31:0] rnd;

  agc_addr_xlate i_agc_addr_xlate (.*);

  always #2 clk = ~clk;

  // Random back-pressure on the response
  initial begin
    rsp_ready = 1'b0;
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      rsp_ready = rnd[0];
    end
  end

  // Run limit from the number of test lines
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("Run timed out after %0d cycles with responses still missing", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic show_mismatch(input string name, input logic [15:0] exp, input logic [15:0] act);
    $display("Mismatch at time %0t: %s expected %h got %h", $time, name, exp, act);
  endtask

  task automatic apply_bank_write(input int line);
    logic [75:0] t;
    t = tests[line];
    @(negedge clk);
    req_valid    = 1'b0;
    bank_wr_en   = 1'b1;
    bank_wr_sel  = t[69:68];
    bank_wr_data = t[66:52];
    @(posedge clk);
    write_count++;
    $display("Test %0d: bank write sel %0d data %h done", line, t[69:68], t[66:52]);
  endtask

  task automatic send_request(input int line);
    logic [75:0] t;
    t = tests[line];
    @(negedge clk);
    bank_wr_en = 1'b0;
    req_valid  = 1'b1;
    req_addr   = t[51:40];
    req_write  = t[36];
    // Hold the request until the handshake edge
    @(posedge clk);
    while (!req_ready) begin
      @(posedge clk);
    end
    exp_line_q.push_back(line);
    exp_addr_q.push_back(t[51:40]);
    exp_is_rom_q.push_back(t[32]);
    exp_rom_q.push_back(t[29:16]);
    exp_ram_q.push_back(t[14:4]);
    exp_write_q.push_back(t[0]);
    req_count++;
  endtask

  // Response monitor, one check per transferred response
  always @(posedge clk) begin : monitor
    int         line;
    soft_addr_t addr;
    logic       e_is_rom;
    rom_addr_t  e_rom;
    ram_addr_t  e_ram;
    logic       e_write;
    logic       ok;
    if (rst_l && rsp_valid && rsp_ready) begin
      rsp_count++;
      if (exp_line_q.size() == 0) begin
        $display("Response at time %0t arrived with no request outstanding", $time);
        monitor_errors++;
      end else begin
        line     = exp_line_q.pop_front();
        addr     = exp_addr_q.pop_front();
        e_is_rom = exp_is_rom_q.pop_front();
        e_rom    = exp_rom_q.pop_front();
        e_ram    = exp_ram_q.pop_front();
        e_write  = exp_write_q.pop_front();
        ok       = 1'b1;
        if (rsp_is_rom !== e_is_rom) begin
          show_mismatch("rsp_is_rom", 16'(e_is_rom), 16'(rsp_is_rom));
          ok = 1'b0;
        end
        if (rsp_rom_addr !== e_rom) begin
          show_mismatch("rsp_rom_addr", 16'(e_rom), 16'(rsp_rom_addr));
          ok = 1'b0;
        end
        if (rsp_ram_addr !== e_ram) begin
          show_mismatch("rsp_ram_addr", 16'(e_ram), 16'(rsp_ram_addr));
          ok = 1'b0;
        end
        if (rsp_write !== e_write) begin
          show_mismatch("rsp_write", 16'(e_write), 16'(rsp_write));
          ok = 1'b0;
        end
        if (ok) begin
          pass_count++;
        end else begin
          fail_count++;
        end
        $display("Test %0d: request %h %s", line, addr, ok ? "ok" : "wrong response");
      end
    end
  end

  initial begin
    rst_l        = 1'b0;
    bank_wr_en   = 1'b0;
    bank_wr_sel  = BANK_SEL_EB;
    bank_wr_data = '0;
    req_valid    = 1'b0;
    req_addr     = '0;
    req_write    = 1'b0;
    for (int i = 0; i < MAX_LINES; i++) begin
      tests[i] = '0;
    end
    $readmemh("bench/xlate_tests.txt", tests);
    num_lines = 0;
    while (num_lines < MAX_LINES && tests[num_lines][75:72] != 4'h0) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("No test lines read from bench/xlate_tests.txt");
      drive_errors++;
    end
    timeout_limit = 20 * num_lines + 100;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_l = 1'b1;
    for (int i = 0; i < num_lines; i++) begin
      if (tests[i][75:72] == 4'h1) begin
        apply_bank_write(i);
      end else if (tests[i][75:72] == 4'h2) begin
        send_request(i);
      end else begin
        $display("Test %0d has an unknown kind %h", i, tests[i][75:72]);
        drive_errors++;
      end
    end
    @(negedge clk);
    req_valid  = 1'b0;
    bank_wr_en = 1'b0;
    // Drain, then watch a few cycles for stray responses
    while (exp_line_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    if (rsp_count != req_count) begin
      $display("Sent %0d requests but saw %0d responses", req_count, rsp_count);
      drive_errors++;
    end
    $display("Summary: %0d requests, %0d passed, %0d wrong, %0d bank writes, %0d other errors",
             req_count, pass_count, fail_count, write_count, drive_errors + monitor_errors);
    if (fail_count == 0 && drive_errors == 0 && monitor_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* bench/xlate_tests.txt */
// kind(1 bank write, 2 request) _ sel _ data _ addr _ write _ exp is_rom _ exp rom _ exp ram _ exp write
// all hex; bank writes use sel and data, requests use the fields after data
2_0_0000_000_0_0_0000_000_0
2_0_0000_2ff_1_0_0000_2ff_1
2_0_0000_800_0_1_0000_000_0
2_0_0000_fff_1_1_07ff_000_0
2_0_0000_400_0_1_0800_000_0
1_1_3000_000_0_0_0000_000_0
2_0_0000_4e5_0_1_14e5_000_0
1_1_7000_000_0_0_0000_000_0
2_0_0000_7ff_0_1_27ff_000_0
1_1_5000_000_0_0_0000_000_0
2_0_0000_400_0_1_1c00_000_0
2_0_0000_800_0_1_0000_000_0
1_0_0400_000_0_0_0000_000_0
2_0_0000_300_0_0_0000_500_0
2_0_0000_3ff_1_0_0000_5ff_1
2_0_0000_040_0_0_0000_040_0
1_0_0a00_000_0_0_0000_000_0
2_0_0000_300_0_0_0000_700_0
2_0_0000_3ff_0_0_0000_7ff_0
1_0_0600_000_0_0_0000_000_0
2_0_0000_340_0_0_0000_640_0
1_2_2200_000_0_0_0000_000_0
2_0_0000_300_0_0_0000_400_0
2_0_0000_400_0_1_1000_000_0
1_0_7c00_000_0_0_0000_000_0
2_0_0000_400_0_1_1000_000_0
2_0_0000_300_0_0_0000_700_0
2_0_0000_0ff_1_0_0000_0ff_1
2_0_0000_c00_1_1_0400_000_0

/* files.f */
source/agc_pkg.sv
source/bank_map_if.sv
source/bank_regs.sv
source/rom_bank_map.sv
source/ram_bank_map.sv
source/access_stage.sv
source/agc_addr_xlate.sv
bench/agc_addr_xlate_checker.sv
bench/agc_addr_xlate_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the translator testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
  --top-module agc_addr_xlate_tb -o agc_addr_xlate_sim
if [ $? -ne 0 ]; then
  echo "Verilator build did not complete"
  exit 1
fi

./obj_dir/agc_addr_xlate_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
exit 0
